//--- rtl/csr_pkg.sv
package csr_pkg;

    // Register map
    localparam logic [7:0] lut_frame     = 8'h00;
    localparam logic [7:0] lut_addr_hi   = 8'h01;
    localparam logic [7:0] lut_addr_lo   = 8'h02;
    localparam logic [7:0] lut_wr        = 8'h03;
    localparam logic [7:0] op_left_hi    = 8'h04;
    localparam logic [7:0] op_left_lo    = 8'h05;
    localparam logic [7:0] op_right_hi   = 8'h06;
    localparam logic [7:0] op_right_lo   = 8'h07;
    localparam logic [7:0] op_top_hi     = 8'h08;
    localparam logic [7:0] op_top_lo     = 8'h09;
    localparam logic [7:0] op_bottom_hi  = 8'h0a;
    localparam logic [7:0] op_bottom_lo  = 8'h0b;
    localparam logic [7:0] op_param      = 8'h0c;
    localparam logic [7:0] op_length     = 8'h0d;
    localparam logic [7:0] op_cmd        = 8'h0e;
    localparam logic [7:0] control       = 8'h0f;
    localparam logic [7:0] cfg_vfp       = 8'h10;
    localparam logic [7:0] cfg_vsync     = 8'h11;
    localparam logic [7:0] cfg_vbp       = 8'h12;
    localparam logic [7:0] cfg_vact_hi   = 8'h13;
    localparam logic [7:0] cfg_vact_lo   = 8'h14;
    localparam logic [7:0] cfg_hfp       = 8'h15;
    localparam logic [7:0] cfg_hsync     = 8'h16;
    localparam logic [7:0] cfg_hbp       = 8'h17;
    localparam logic [7:0] cfg_hact_hi   = 8'h18;
    localparam logic [7:0] cfg_hact_lo   = 8'h19;
    localparam logic [7:0] cfg_fbytes_b2 = 8'h1a;
    localparam logic [7:0] cfg_fbytes_b1 = 8'h1b;
    localparam logic [7:0] cfg_fbytes_b0 = 8'h1c;

    // Frame index of the default waveform
    localparam logic [5:0] lut_frame_reset = 6'd38;

    // Control register, written as an enable and read back as status
    typedef union packed {
        struct packed {
            logic       mem_error;
            logic       if_error;
            logic       sys_ready;
            logic       op_busy;
            logic       op_queue;
            logic [1:0] rsvd;
            logic       en;
        } status;
        struct packed {
            logic [6:0] ignored;
            logic       en;
        } ctrl;
    } ctrl_word_u;

endpackage

//--- rtl/timing_pkg.sv
package timing_pkg;

    // Field widths
    localparam int coord_w  = 12;
    localparam int porch_w  = 8;
    localparam int fbytes_w = 24;

    // Panel timing loaded at reset in self-boot builds
    localparam logic [porch_w-1:0]  default_vfp    = 8'd12;
    localparam logic [porch_w-1:0]  default_vsync  = 8'd1;
    localparam logic [porch_w-1:0]  default_vbp    = 8'd2;
    localparam logic [coord_w-1:0]  default_vact   = 12'd1200;
    localparam logic [porch_w-1:0]  default_hfp    = 8'd2;
    localparam logic [porch_w-1:0]  default_hsync  = 8'd1;
    localparam logic [porch_w-1:0]  default_hbp    = 8'd2;
    localparam logic [coord_w-1:0]  default_hact   = 12'd400;
    localparam logic [fbytes_w-1:0] default_fbytes = 24'd480000;

endpackage

//--- rtl/spi_target.sv
`timescale 1ns/10ps

module spi_target (
    input  logic       clk,
    input  logic       rst,
    input  logic       spi_cs,
    input  logic       spi_sck,
    input  logic       spi_mosi,
    output logic       spi_miso,
    output logic [7:0] req_addr,
    output logic [7:0] req_wdata,
    output logic       req_ren,
    output logic       req_wen,
    input  logic [7:0] req_rdata
);

    // Mode 3: SCK idles high, MOSI sampled on rising edge, MISO driven on falling edge
    localparam logic phase_addr = 1'b0;
    localparam logic phase_data = 1'b1;

    logic       sck_prev;
    logic       phase;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;
    logic [7:0] rx_next;
    logic       sck_rise;
    logic       sck_fall;
    logic       auto_inc;

    assign rx_next  = {rx_shift, spi_mosi};
    assign sck_rise = !sck_prev && spi_sck;
    assign sck_fall = sck_prev && !spi_sck;

    // LUT and command writes stream into one address
    assign auto_inc = (req_addr != csr_pkg::lut_wr) && (req_addr != csr_pkg::op_cmd);

    always_ff @(posedge clk) begin
        if (rst) begin
            sck_prev <= 1'b1;
            phase    <= phase_addr;
            bit_cnt  <= 3'd0;
            req_ren  <= 1'b0;
            req_wen  <= 1'b0;
            spi_miso <= 1'b1;
        end else begin
            sck_prev <= spi_sck;
            req_ren  <= 1'b0;
            req_wen  <= 1'b0;

            if (req_wen && auto_inc) begin
                req_addr <= req_addr + 8'd1;
            end

            if (spi_cs) begin
                // Deselected, wait for the next address byte
                bit_cnt  <= 3'd0;
                phase    <= phase_addr;
                tx_shift <= 8'hff;
            end else begin
                // Read data arrives one clk after the address byte
                if (req_ren) begin
                    tx_shift <= req_rdata;
                end

                if (sck_rise) begin
                    rx_shift <= rx_next[6:0];
                    bit_cnt  <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        if (phase == phase_addr) begin
                            req_addr <= rx_next;
                            req_ren  <= 1'b1;
                            phase    <= phase_data;
                        end else begin
                            req_wdata <= rx_next;
                            req_wen   <= 1'b1;
                        end
                    end
                end else if (sck_fall) begin
                    spi_miso <= tx_shift[7];
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

endmodule

//--- rtl/csr_bank.sv
`timescale 1ns/10ps

module csr_bank #(
    parameter bit self_boot = 1'b0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [7:0]                      req_addr,
    input  logic [7:0]                      req_wdata,
    input  logic                            req_wen,
    output logic [7:0]                      req_rdata,
    input  logic                            sys_ready,
    input  logic                            mem_error,
    input  logic                            if_error,
    input  logic                            op_busy,
    input  logic                            op_queue,
    output logic [5:0]                      lut_frame,
    output logic [11:0]                     lut_addr,
    output logic [7:0]                      lut_wr,
    output logic                            lut_we,
    output logic [timing_pkg::coord_w-1:0]  op_left,
    output logic [timing_pkg::coord_w-1:0]  op_right,
    output logic [timing_pkg::coord_w-1:0]  op_top,
    output logic [timing_pkg::coord_w-1:0]  op_bottom,
    output logic [7:0]                      op_param,
    output logic [7:0]                      op_length,
    output logic [7:0]                      op_cmd,
    output logic                            op_valid,
    output logic                            ctrl_en,
    output logic [timing_pkg::porch_w-1:0]  cfg_vfp,
    output logic [timing_pkg::porch_w-1:0]  cfg_vsync,
    output logic [timing_pkg::porch_w-1:0]  cfg_vbp,
    output logic [timing_pkg::coord_w-1:0]  cfg_vact,
    output logic [timing_pkg::porch_w-1:0]  cfg_hfp,
    output logic [timing_pkg::porch_w-1:0]  cfg_hsync,
    output logic [timing_pkg::porch_w-1:0]  cfg_hbp,
    output logic [timing_pkg::coord_w-1:0]  cfg_hact,
    output logic [timing_pkg::fbytes_w-1:0] cfg_fbytes
);

    csr_pkg::ctrl_word_u wr_word;
    csr_pkg::ctrl_word_u rd_word;

    assign wr_word = req_wdata;

    // Status view of the control word
    always_comb begin
        rd_word                  = '0;
        rd_word.status.mem_error = mem_error;
        rd_word.status.if_error  = if_error;
        rd_word.status.sys_ready = sys_ready;
        rd_word.status.op_busy   = op_busy;
        rd_word.status.op_queue  = op_queue;
        rd_word.status.en        = ctrl_en;
    end

    assign req_rdata = (req_addr == csr_pkg::control) ? rd_word : 8'h00;

    always_ff @(posedge clk) begin
        if (rst) begin
            lut_frame <= csr_pkg::lut_frame_reset;
            lut_we    <= 1'b0;
            op_valid  <= 1'b0;
            if (self_boot) begin
                ctrl_en    <= 1'b1;
                cfg_vfp    <= timing_pkg::default_vfp;
                cfg_vsync  <= timing_pkg::default_vsync;
                cfg_vbp    <= timing_pkg::default_vbp;
                cfg_vact   <= timing_pkg::default_vact;
                cfg_hfp    <= timing_pkg::default_hfp;
                cfg_hsync  <= timing_pkg::default_hsync;
                cfg_hbp    <= timing_pkg::default_hbp;
                cfg_hact   <= timing_pkg::default_hact;
                cfg_fbytes <= timing_pkg::default_fbytes;
            end else begin
                ctrl_en <= 1'b0;
            end
        end else begin
            lut_we   <= 1'b0;
            op_valid <= 1'b0;
            if (req_wen) begin
                // High bytes carry only the top nibble of 12-bit fields
                case (req_addr)
                    csr_pkg::lut_frame:     lut_frame         <= req_wdata[5:0];
                    csr_pkg::lut_addr_hi:   lut_addr[11:8]    <= req_wdata[3:0];
                    csr_pkg::lut_addr_lo:   lut_addr[7:0]     <= req_wdata;
                    csr_pkg::lut_wr: begin
                        lut_wr <= req_wdata;
                        lut_we <= 1'b1;
                    end
                    csr_pkg::op_left_hi:    op_left[11:8]     <= req_wdata[3:0];
                    csr_pkg::op_left_lo:    op_left[7:0]      <= req_wdata;
                    csr_pkg::op_right_hi:   op_right[11:8]    <= req_wdata[3:0];
                    csr_pkg::op_right_lo:   op_right[7:0]     <= req_wdata;
                    csr_pkg::op_top_hi:     op_top[11:8]      <= req_wdata[3:0];
                    csr_pkg::op_top_lo:     op_top[7:0]       <= req_wdata;
                    csr_pkg::op_bottom_hi:  op_bottom[11:8]   <= req_wdata[3:0];
                    csr_pkg::op_bottom_lo:  op_bottom[7:0]    <= req_wdata;
                    csr_pkg::op_param:      op_param          <= req_wdata;
                    csr_pkg::op_length:     op_length         <= req_wdata;
                    csr_pkg::op_cmd: begin
                        op_cmd   <= req_wdata;
                        op_valid <= 1'b1;
                    end
                    csr_pkg::control:       ctrl_en           <= wr_word.ctrl.en;
                    csr_pkg::cfg_vfp:       cfg_vfp           <= req_wdata;
                    csr_pkg::cfg_vsync:     cfg_vsync         <= req_wdata;
                    csr_pkg::cfg_vbp:       cfg_vbp           <= req_wdata;
                    csr_pkg::cfg_vact_hi:   cfg_vact[11:8]    <= req_wdata[3:0];
                    csr_pkg::cfg_vact_lo:   cfg_vact[7:0]     <= req_wdata;
                    csr_pkg::cfg_hfp:       cfg_hfp           <= req_wdata;
                    csr_pkg::cfg_hsync:     cfg_hsync         <= req_wdata;
                    csr_pkg::cfg_hbp:       cfg_hbp           <= req_wdata;
                    csr_pkg::cfg_hact_hi:   cfg_hact[11:8]    <= req_wdata[3:0];
                    csr_pkg::cfg_hact_lo:   cfg_hact[7:0]     <= req_wdata;
                    csr_pkg::cfg_fbytes_b2: cfg_fbytes[23:16] <= req_wdata;
                    csr_pkg::cfg_fbytes_b1: cfg_fbytes[15:8]  <= req_wdata;
                    csr_pkg::cfg_fbytes_b0: cfg_fbytes[7:0]   <= req_wdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- rtl/frame_timing.sv
`timescale 1ns/10ps

module frame_timing (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  logic [timing_pkg::porch_w-1:0] vfp,
    input  logic [timing_pkg::porch_w-1:0] vsync,
    input  logic [timing_pkg::porch_w-1:0] vbp,
    input  logic [timing_pkg::coord_w-1:0] vact,
    input  logic [timing_pkg::porch_w-1:0] hfp,
    input  logic [timing_pkg::porch_w-1:0] hsync,
    input  logic [timing_pkg::porch_w-1:0] hbp,
    input  logic [timing_pkg::coord_w-1:0] hact,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           de,
    output logic                           frame_start
);

    // One extra bit covers the porches on top of the active size
    localparam int cnt_w = timing_pkg::coord_w + 1;

    logic [cnt_w-1:0] h_cnt;
    logic [cnt_w-1:0] v_cnt;
    logic [cnt_w-1:0] h_act_start;
    logic [cnt_w-1:0] h_act_end;
    logic [cnt_w-1:0] h_total;
    logic [cnt_w-1:0] v_act_start;
    logic [cnt_w-1:0] v_act_end;
    logic [cnt_w-1:0] v_total;
    logic             line_end;

    // Each line and frame runs sync, back porch, active, front porch
    assign h_act_start = cnt_w'(hsync) + cnt_w'(hbp);
    assign h_act_end   = h_act_start + cnt_w'(hact);
    assign h_total     = h_act_end + cnt_w'(hfp);
    assign v_act_start = cnt_w'(vsync) + cnt_w'(vbp);
    assign v_act_end   = v_act_start + cnt_w'(vact);
    assign v_total     = v_act_end + cnt_w'(vfp);

    assign line_end = (h_cnt == h_total - cnt_w'(1));

    always_ff @(posedge clk) begin
        if (rst || !en) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            hsync_o     <= 1'b0;
            vsync_o     <= 1'b0;
            de          <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            h_cnt <= line_end ? '0 : h_cnt + cnt_w'(1);
            if (line_end) begin
                v_cnt <= (v_cnt == v_total - cnt_w'(1)) ? '0 : v_cnt + cnt_w'(1);
            end
            hsync_o     <= h_cnt < cnt_w'(hsync);
            vsync_o     <= v_cnt < cnt_w'(vsync);
            de          <= (h_cnt >= h_act_start) && (h_cnt < h_act_end) &&
                           (v_cnt >= v_act_start) && (v_cnt < v_act_end);
            frame_start <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

endmodule

//--- rtl/epd_ctrl_top.sv
`timescale 1ns/10ps

module epd_ctrl_top #(
    parameter bit self_boot = 1'b0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            spi_cs,
    input  logic                            spi_sck,
    input  logic                            spi_mosi,
    output logic                            spi_miso,
    input  logic                            sys_ready,
    input  logic                            mem_error,
    input  logic                            if_error,
    input  logic                            op_busy,
    input  logic                            op_queue,
    output logic [5:0]                      lut_frame,
    output logic [11:0]                     lut_addr,
    output logic [7:0]                      lut_wr,
    output logic                            lut_we,
    output logic [timing_pkg::coord_w-1:0]  op_left,
    output logic [timing_pkg::coord_w-1:0]  op_right,
    output logic [timing_pkg::coord_w-1:0]  op_top,
    output logic [timing_pkg::coord_w-1:0]  op_bottom,
    output logic [7:0]                      op_param,
    output logic [7:0]                      op_length,
    output logic [7:0]                      op_cmd,
    output logic                            op_valid,
    output logic                            ctrl_en,
    output logic [timing_pkg::porch_w-1:0]  cfg_vfp,
    output logic [timing_pkg::porch_w-1:0]  cfg_vsync,
    output logic [timing_pkg::porch_w-1:0]  cfg_vbp,
    output logic [timing_pkg::coord_w-1:0]  cfg_vact,
    output logic [timing_pkg::porch_w-1:0]  cfg_hfp,
    output logic [timing_pkg::porch_w-1:0]  cfg_hsync,
    output logic [timing_pkg::porch_w-1:0]  cfg_hbp,
    output logic [timing_pkg::coord_w-1:0]  cfg_hact,
    output logic [timing_pkg::fbytes_w-1:0] cfg_fbytes,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            de,
    output logic                            frame_start
);

    // SPI request path into the register bank
    logic [7:0] req_addr;
    logic [7:0] req_wdata;
    logic [7:0] req_rdata;
    logic       req_ren;
    logic       req_wen;

    spi_target u_spi (
        .clk       (clk),
        .rst       (rst),
        .spi_cs    (spi_cs),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ren   (req_ren),
        .req_wen   (req_wen),
        .req_rdata (req_rdata)
    );

    csr_bank #(
        .self_boot (self_boot)
    ) u_csr (
        .clk        (clk),
        .rst        (rst),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wen    (req_wen),
        .req_rdata  (req_rdata),
        .sys_ready  (sys_ready),
        .mem_error  (mem_error),
        .if_error   (if_error),
        .op_busy    (op_busy),
        .op_queue   (op_queue),
        .lut_frame  (lut_frame),
        .lut_addr   (lut_addr),
        .lut_wr     (lut_wr),
        .lut_we     (lut_we),
        .op_left    (op_left),
        .op_right   (op_right),
        .op_top     (op_top),
        .op_bottom  (op_bottom),
        .op_param   (op_param),
        .op_length  (op_length),
        .op_cmd     (op_cmd),
        .op_valid   (op_valid),
        .ctrl_en    (ctrl_en),
        .cfg_vfp    (cfg_vfp),
        .cfg_vsync  (cfg_vsync),
        .cfg_vbp    (cfg_vbp),
        .cfg_vact   (cfg_vact),
        .cfg_hfp    (cfg_hfp),
        .cfg_hsync  (cfg_hsync),
        .cfg_hbp    (cfg_hbp),
        .cfg_hact   (cfg_hact),
        .cfg_fbytes (cfg_fbytes)
    );

    frame_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .en          (ctrl_en),
        .vfp         (cfg_vfp),
        .vsync       (cfg_vsync),
        .vbp         (cfg_vbp),
        .vact        (cfg_vact),
        .hfp         (cfg_hfp),
        .hsync       (cfg_hsync),
        .hbp         (cfg_hbp),
        .hact        (cfg_hact),
        .hsync_o     (hsync),
        .vsync_o     (vsync),
        .de          (de),
        .frame_start (frame_start)
    );

endmodule

//--- tests/epd_ctrl_checker.sv
`timescale 1ns/10ps

module epd_ctrl_checker #(
    parameter bit self_boot = 1'b0
) (
    input logic                           clk,
    input logic                           rst,
    input logic                           ctrl_en,
    input logic [5:0]                     lut_frame,
    input logic                           lut_we,
    input logic                           op_valid,
    input logic                           hsync,
    input logic                           vsync,
    input logic                           de,
    input logic                           frame_start,
    input logic [timing_pkg::porch_w-1:0] cfg_hsync,
    input logic [timing_pkg::porch_w-1:0] cfg_hbp,
    input logic [timing_pkg::porch_w-1:0] cfg_hfp,
    input logic [timing_pkg::coord_w-1:0] cfg_hact,
    input logic [timing_pkg::porch_w-1:0] cfg_vsync,
    input logic [timing_pkg::porch_w-1:0] cfg_vbp,
    input logic [timing_pkg::porch_w-1:0] cfg_vfp,
    input logic [timing_pkg::coord_w-1:0] cfg_vact
);

    int          fail_count = 0;
    logic [7:0]  hs_len;
    logic [11:0] de_len;
    logic [31:0] gap;
    logic        seen;
    logic [15:0] line_total;
    logic [15:0] frame_lines;
    logic [31:0] frame_total;

    assign line_total  = 16'(cfg_hsync) + 16'(cfg_hbp) + 16'(cfg_hact) + 16'(cfg_hfp);
    assign frame_lines = 16'(cfg_vsync) + 16'(cfg_vbp) + 16'(cfg_vact) + 16'(cfg_vfp);
    assign frame_total = 32'(line_total) * 32'(frame_lines);

    // Run lengths of hsync and de, and clk count since the last frame start
    always_ff @(posedge clk) begin
        if (rst) begin
            hs_len <= 8'd0;
            de_len <= 12'd0;
            gap    <= 32'd0;
            seen   <= 1'b0;
        end else begin
            hs_len <= hsync ? hs_len + 8'd1 : 8'd0;
            de_len <= de ? de_len + 12'd1 : 12'd0;
            gap    <= frame_start ? 32'd1 : gap + 32'd1;
            seen   <= ctrl_en && (seen || frame_start);
        end
    end

    a_reset: assert property (@(posedge clk) $fell(rst) |->
        (lut_frame == csr_pkg::lut_frame_reset) && (ctrl_en == self_boot) && !lut_we &&
        !op_valid && !hsync && !vsync && !de && !frame_start)
        else begin
            fail_count++;
            $error("Register outputs wrong after reset");
        end

    a_lut_we_pulse: assert property (@(posedge clk) disable iff (rst) lut_we |=> !lut_we)
        else begin
            fail_count++;
            $error("lut_we high for more than one clk");
        end

    a_op_valid_pulse: assert property (@(posedge clk) disable iff (rst) op_valid |=> !op_valid)
        else begin
            fail_count++;
            $error("op_valid high for more than one clk");
        end

    a_hsync_width: assert property (@(posedge clk) disable iff (rst || !ctrl_en)
        $fell(hsync) |-> hs_len == cfg_hsync)
        else begin
            fail_count++;
            $error("hsync width differs from cfg_hsync");
        end

    a_de_width: assert property (@(posedge clk) disable iff (rst || !ctrl_en)
        $fell(de) |-> de_len == cfg_hact)
        else begin
            fail_count++;
            $error("de width differs from cfg_hact");
        end

    // First frame start after enable has no previous one to measure from
    a_frame_period: assert property (@(posedge clk) disable iff (rst || !ctrl_en)
        (frame_start && seen) |-> gap == frame_total)
        else begin
            fail_count++;
            $error("Frame period differs from line total times frame lines");
        end

    a_de_outside_sync: assert property (@(posedge clk) disable iff (rst)
        !(de && (hsync || vsync)))
        else begin
            fail_count++;
            $error("de high during hsync or vsync");
        end

    a_disabled_quiet: assert property (@(posedge clk) disable iff (rst)
        !ctrl_en |=> !hsync && !vsync && !de && !frame_start)
        else begin
            fail_count++;
            $error("Timing outputs active while disabled");
        end

endmodule

bind epd_ctrl_top epd_ctrl_checker #(.self_boot(self_boot)) u_chk (.*);

//--- tests/epd_ctrl_tb.sv
`timescale 1ns/10ps

module epd_ctrl_tb;

    localparam int clk_period = 20;
    localparam int half_sck   = 4;
    // Roughly 52 bytes on the bus, a gap per transaction, and a few frames
    localparam int byte_clk    = 16 * half_sck;
    localparam int run_clk     = 52 * byte_clk + 12 * 16 + 5 * 60;
    localparam int watchdog_ns = 2 * run_clk * clk_period;

    // Small panel timing, order follows cfg_vfp through cfg_hact_lo
    localparam logic [7:0] small_timing [10] = '{
        8'd1, 8'd1, 8'd1, 8'd0, 8'd3, 8'd2, 8'd2, 8'd2, 8'd0, 8'd4
    };

    typedef logic [7:0] byte_q_t[$];

    logic        clk;
    logic        rst;
    logic        spi_cs;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;
    logic        sys_ready;
    logic        mem_error;
    logic        if_error;
    logic        op_busy;
    logic        op_queue;
    logic [5:0]  lut_frame;
    logic [11:0] lut_addr;
    logic [7:0]  lut_wr;
    logic        lut_we;
    logic [11:0] op_left;
    logic [11:0] op_right;
    logic [11:0] op_top;
    logic [11:0] op_bottom;
    logic [7:0]  op_param;
    logic [7:0]  op_length;
    logic [7:0]  op_cmd;
    logic        op_valid;
    logic        ctrl_en;
    logic [7:0]  cfg_vfp;
    logic [7:0]  cfg_vsync;
    logic [7:0]  cfg_vbp;
    logic [11:0] cfg_vact;
    logic [7:0]  cfg_hfp;
    logic [7:0]  cfg_hsync;
    logic [7:0]  cfg_hbp;
    logic [11:0] cfg_hact;
    logic [23:0] cfg_fbytes;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic        frame_start;

    integer              seed = 49;
    byte_q_t             burst;
    byte_q_t             lut_seen;
    byte_q_t             cmd_seen;
    logic [7:0]          rd;
    logic [11:0]         lut_addr_exp;
    logic [23:0]         fbytes_exp;
    csr_pkg::ctrl_word_u exp_word;

    epd_ctrl_top #(.self_boot(1'b0)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run took longer than the transactions allow");
        $display(">>> FAIL");
        $fatal(1);
    end

    // Strobed bytes, sampled away from the active edge
    always @(negedge clk) begin
        if (lut_we) begin
            lut_seen.push_back(lut_wr);
        end
        if (op_valid) begin
            cmd_seen.push_back(op_cmd);
        end
    end

    always @(negedge clk) begin
        if (uut.u_chk.fail_count != 0) begin
            $display("An assertion in the checker failed at %0t", $time);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    function automatic byte_q_t random_bytes(input int n);
        byte_q_t q;
        for (int i = 0; i < n; i++) begin
            q.push_back(8'($random(seed)));
        end
        return q;
    endfunction

    task automatic compare_value(input string name, input logic [23:0] got,
                                 input logic [23:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // Mode 3 bit, MISO taken just before SCK rises
    task automatic spi_bit(input logic mosi_bit, output logic miso_bit);
        spi_sck  <= 1'b0;
        spi_mosi <= mosi_bit;
        repeat (half_sck) @(posedge clk);
        miso_bit = spi_miso;
        spi_sck <= 1'b1;
        repeat (half_sck) @(posedge clk);
    endtask

    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        logic b;
        for (int i = 7; i >= 0; i--) begin
            spi_bit(tx[i], b);
            rx[i] = b;
        end
    endtask

    task automatic spi_write_burst(input logic [7:0] addr, input byte_q_t data);
        logic [7:0] rx;
        spi_cs <= 1'b0;
        repeat (half_sck) @(posedge clk);
        spi_byte(addr, rx);
        foreach (data[i]) begin
            spi_byte(data[i], rx);
        end
        spi_cs <= 1'b1;
        repeat (2 * half_sck) @(posedge clk);
    endtask

    // The data byte is also written, so callers pick a harmless value
    task automatic spi_read(input logic [7:0] addr, input logic [7:0] wbyte,
                            output logic [7:0] rbyte);
        logic [7:0] rx;
        spi_cs <= 1'b0;
        repeat (half_sck) @(posedge clk);
        spi_byte(addr, rx);
        spi_byte(wbyte, rbyte);
        spi_cs <= 1'b1;
        repeat (2 * half_sck) @(posedge clk);
    endtask

    initial begin
        rst       = 1'b1;
        spi_cs    = 1'b1;
        spi_sck   = 1'b1;
        spi_mosi  = 1'b0;
        sys_ready = 1'b0;
        mem_error = 1'b0;
        if_error  = 1'b0;
        op_busy   = 1'b0;
        op_queue  = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // One burst from op_left_hi through op_length
        burst = random_bytes(10);
        spi_write_burst(csr_pkg::op_left_hi, burst);
        compare_value("op_left", 24'(op_left), 24'({burst[0][3:0], burst[1]}));
        compare_value("op_right", 24'(op_right), 24'({burst[2][3:0], burst[3]}));
        compare_value("op_top", 24'(op_top), 24'({burst[4][3:0], burst[5]}));
        compare_value("op_bottom", 24'(op_bottom), 24'({burst[6][3:0], burst[7]}));
        compare_value("op_param", 24'(op_param), 24'(burst[8]));
        compare_value("op_length", 24'(op_length), 24'(burst[9]));

        burst = random_bytes(2);
        lut_addr_exp = {burst[0][3:0], burst[1]};
        spi_write_burst(csr_pkg::lut_addr_hi, burst);

        // Streaming ports keep their address for the whole transaction
        lut_seen.delete();
        burst = random_bytes(5);
        spi_write_burst(csr_pkg::lut_wr, burst);
        compare_value("lut_we pulses", 24'(lut_seen.size()), 24'(burst.size()));
        foreach (burst[i]) begin
            compare_value("lut_wr", 24'(lut_seen[i]), 24'(burst[i]));
        end
        compare_value("lut_addr", 24'(lut_addr), 24'(lut_addr_exp));

        cmd_seen.delete();
        burst = random_bytes(4);
        spi_write_burst(csr_pkg::op_cmd, burst);
        compare_value("op_valid pulses", 24'(cmd_seen.size()), 24'(burst.size()));
        foreach (burst[i]) begin
            compare_value("op_cmd", 24'(cmd_seen[i]), 24'(burst[i]));
        end

        burst.delete();
        foreach (small_timing[i]) begin
            burst.push_back(small_timing[i]);
        end
        // Frame byte count follows the timing fields, most significant byte first
        fbytes_exp = 24'($random(seed));
        burst.push_back(fbytes_exp[23:16]);
        burst.push_back(fbytes_exp[15:8]);
        burst.push_back(fbytes_exp[7:0]);
        spi_write_burst(csr_pkg::cfg_vfp, burst);
        compare_value("cfg_vfp", 24'(cfg_vfp), 24'(small_timing[0]));
        compare_value("cfg_vsync", 24'(cfg_vsync), 24'(small_timing[1]));
        compare_value("cfg_vbp", 24'(cfg_vbp), 24'(small_timing[2]));
        compare_value("cfg_vact", 24'(cfg_vact), 24'({small_timing[3][3:0], small_timing[4]}));
        compare_value("cfg_hfp", 24'(cfg_hfp), 24'(small_timing[5]));
        compare_value("cfg_hsync", 24'(cfg_hsync), 24'(small_timing[6]));
        compare_value("cfg_hbp", 24'(cfg_hbp), 24'(small_timing[7]));
        compare_value("cfg_hact", 24'(cfg_hact), 24'({small_timing[8][3:0], small_timing[9]}));
        compare_value("cfg_fbytes", cfg_fbytes, fbytes_exp);

        // Enable with random upper bits, then read status back
        {mem_error, if_error, sys_ready, op_busy, op_queue} <= 5'($random(seed));
        burst = random_bytes(1);
        burst[0][0] = 1'b1;
        spi_write_burst(csr_pkg::control, burst);
        exp_word                  = '0;
        exp_word.status.mem_error = mem_error;
        exp_word.status.if_error  = if_error;
        exp_word.status.sys_ready = sys_ready;
        exp_word.status.op_busy   = op_busy;
        exp_word.status.op_queue  = op_queue;
        exp_word.status.en        = 1'b1;
        spi_read(csr_pkg::control, 8'h01, rd);
        compare_value("control readback", 24'(rd), 24'(exp_word));
        spi_read(csr_pkg::op_param, op_param, rd);
        compare_value("op_param readback", 24'(rd), 24'h0);
        spi_read(8'h7f, 8'h5a, rd);
        compare_value("unmapped readback", 24'(rd), 24'h0);

        repeat (3) @(posedge frame_start);

        burst.delete();
        burst.push_back(8'h00);
        spi_write_burst(csr_pkg::control, burst);
        repeat (10) @(posedge clk);

        if (uut.u_chk.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1);
        end
    end

endmodule

//--- vlog.f
rtl/csr_pkg.sv
rtl/timing_pkg.sv
rtl/spi_target.sv
rtl/csr_bank.sv
rtl/frame_timing.sv
rtl/epd_ctrl_top.sv
tests/epd_ctrl_checker.sv
tests/epd_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= epd_ctrl_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/10ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f vlog.f
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
